/* verif/iot_input.dat */
3 4 0
00000000000000000000000000000000 00000000000000000000000000000001
80000000000000000000000000000001 000000000000000000000000000000ff
0 5 2 5
3 4 1
ffffffffffffffffffffffffffffffff 10 100 100000000
2 1 7 1
4 16 0
7f000000000000000000000000000001 7f000000000000000000000000000003
7f000000000000000000000000000002 10
7e0000000000000000000000000000ff 0
5 7f000000000000000000000000000000
aa0000000001 aa0000000100 aa0000010000 a9ffffffffff
aa0000000101 0 aa0000000010 aa0000000001
7f000000000000000000000000000003 7f000000000000000000000000000002
aa0000010000 aa0000000101
5 8 1
500 30 7000 30 31 ffff 40 900
30 30
4 16 2
1 2 3 4 5 6 7 8
ff 1ff fe 100 2 1fe 0 17
8 7 1ff 1fe

/* vlog.f */
+incdir+src
src/iotdf_pkg.sv
src/block_collector.sv
src/crc3_engine.sv
src/extreme_tracker.sv
src/iotdf_ctrl.sv
src/iotdf.sv
verif/tb_iotdf.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_iotdf
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_iotdf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iotdf_defs.svh"

module tb_iotdf
	import iotdf_pkg::*;
();

	localparam int CLK_HALF = 50;      // 100 ns period
	localparam int RST_CYCLES = 10;
	localparam int CRC_LAT = 18;       // last byte edge to crc valid
	localparam int IDLE_CHECK = 4;     // quiet cycles right after reset
	localparam int TAIL_CYCLES = 24;   // watch for stray valid after a test

	logic clk;
	logic rst;
	logic in_en;
	logic [`IOT_BYTE_W-1:0] iot_in;
	logic [2:0] fn_sel;
	logic busy;
	logic valid;
	block_t iot_out;

	integer seed = 32'hd420;
	integer fd;
	int cyc = 0;                       // rising edges so far
	int wd_start = 0;
	int wd_limit = 1000;
	int errors = 0;
	int tests = 0;
	int round_edge = -100;             // last byte edge of the latest round
	logic active = 1'b0;               // monitor armed
	fn_sel_e fn_test = fn_crc_gen;
	block_t blocks[$];                 // stimulus of the current test
	block_t exp_q[$];                  // results still owed by the DUT
	int edge_q[$];                     // last byte edge per crc block

	iotdf i_iotdf (
		.clk     (clk),
		.rst     (rst),
		.in_en   (in_en),
		.iot_in  (iot_in),
		.fn_sel  (fn_sel),
		.busy    (busy),
		.valid   (valid),
		.iot_out (iot_out)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// per test budget restarted by run_test
	always @(posedge clk) begin
		if (cyc - wd_start > wd_limit) begin
			$display("timeout: test %0d still running after %0d cycles", tests, wd_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_block(input string name, input block_t got, input block_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_fn(input string name, input fn_sel_e got, input fn_sel_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// output monitor sampled mid cycle
	always @(negedge clk) begin
		block_t want;
		int lat;
		logic in_win;
		if (active) begin
			// two output cycles start one edge after a round's last byte
			in_win = (fn_test != fn_crc_gen) &&
				(cyc == round_edge + 1 || cyc == round_edge + 2);
			if (busy !== in_win) begin
				$display("CHECK FAILED busy got %h expected %h at cycle %0d",
					busy, in_win, cyc);
				errors++;
			end
			if (fn_test != fn_crc_gen && valid !== in_win) begin
				$display("CHECK FAILED valid got %h expected %h at cycle %0d",
					valid, in_win, cyc);
				errors++;
			end
			if (valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("unexpected valid pulse at cycle %0d, iot_out %h", cyc, iot_out);
					errors++;
				end else begin
					want = exp_q.pop_front();
					check_block("iot_out", iot_out, want);
					if (fn_test == fn_crc_gen && edge_q.size() > 0) begin
						lat = cyc - edge_q.pop_front();
						if (lat != CRC_LAT) begin
							$display("crc result came %0d edges after its last byte, not %0d",
								lat, CRC_LAT);
							errors++;
						end
					end
				end
			end else if (valid !== 1'b0) begin
				$display("valid is unknown at cycle %0d", cyc);
				errors++;
			end
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	// gap_mode 0 dense, 1 random gaps, 2 junk bytes while busy
	task automatic drive_blocks(input int gap_mode);
		int b;
		int k;
		block_t blk;
		b = 0;
		k = 0;
		while (b < blocks.size()) begin
			@(negedge clk);
			blk = blocks[b];
			if (gap_mode == 1 && ($random(seed) & 3) == 0) begin
				in_en = 1'b0;
				iot_in = '0;
			end else if (busy) begin
				in_en = (gap_mode == 2);        // must be dropped by the DUT
				iot_in = 8'($random(seed));
			end else begin
				in_en = 1'b1;
				iot_in = blk[k*`IOT_BYTE_W +: `IOT_BYTE_W];  // lane 0 first
				if (k == `IOT_BLOCK_BYTES - 1) begin
					if (fn_test == fn_crc_gen)
						edge_q.push_back(cyc + 1);  // sampled on the next edge
					else if ((b + 1) % `IOT_ROUND_BLOCKS == 0)
						round_edge = cyc + 1;       // eighth block of a round
					k = 0;
					b++;
				end else begin
					k++;
				end
			end
		end
		@(negedge clk);
		in_en = 1'b0;
		iot_in = '0;
	endtask

	task automatic run_test(input fn_sel_e fn, input int nblk, input int gap_mode);
		int start_err;
		int waited;
		start_err = errors;
		wd_start = cyc;
		wd_limit = 2 * (nblk * `IOT_BLOCK_BYTES + 40);
		active = 1'b0;
		round_edge = -100;
		@(negedge clk);
		fn_test = fn;
		fn_sel = fn;                        // constant until the next reset
		in_en = 1'b0;
		iot_in = '0;
		rst = 1'b1;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);                     // busy drops on the first clock
		check_fn("fn_cur", i_iotdf.fn_cur, fn);
		active = 1'b1;
		repeat (IDLE_CHECK) begin
			@(negedge clk);
			if (busy !== 1'b0 || valid !== 1'b0) begin
				$display("busy or valid high while idle after reset, cycle %0d", cyc);
				errors++;
			end
		end
		drive_blocks(gap_mode);
		waited = 0;
		while (exp_q.size() > 0 && waited < CRC_LAT + 8) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() > 0) begin
			$display("missing %0d valid pulses at the end of the test", exp_q.size());
			errors++;
			exp_q.delete();
			edge_q.delete();
		end
		repeat (TAIL_CYCLES) @(negedge clk);
		active = 1'b0;
		$display("test %0d: %s, %0d blocks, gap mode %0d, %0d errors", tests, fn.name(),
			nblk, gap_mode, errors - start_err);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int fn_code;
		int nblk;
		int gap_mode;
		int nexp;
		block_t v;
		fn_sel_e fn;
		rst = 1'b1;
		in_en = 1'b0;
		iot_in = '0;
		fn_sel = 3'd0;
		fd = $fopen("verif/iot_input.dat", "r");
		if (fd == 0) begin
			$display("cannot open verif/iot_input.dat");
			errors++;
		end else begin
			while ($fscanf(fd, "%h %d %d", fn_code, nblk, gap_mode) == 3) begin
				blocks.delete();
				exp_q.delete();
				edge_q.delete();
				fn = fn_sel_e'(fn_code[2:0]);
				for (int i = 0; i < nblk; i++) begin
					if ($fscanf(fd, "%h", v) != 1) begin
						$display("block %0d of test %0d missing in data file", i, tests + 1);
						errors++;
					end
					blocks.push_back(v);
				end
				// one result per crc block, two per round otherwise
				nexp = (fn == fn_crc_gen) ? nblk : 2 * (nblk / `IOT_ROUND_BLOCKS);
				for (int i = 0; i < nexp; i++) begin
					if ($fscanf(fd, "%h", v) != 1) begin
						$display("expected value %0d of test %0d missing", i, tests + 1);
						errors++;
					end
					exp_q.push_back(v);
				end
				tests++;
				run_test(fn, nblk, gap_mode);
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && tests > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/iotdf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iotdf_defs.svh"

module iotdf
	import iotdf_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic in_en,
	input  logic [`IOT_BYTE_W-1:0] iot_in,
	input  logic [2:0] fn_sel,
	output logic busy,
	output logic valid,
	output block_t iot_out
);

	byte_strb_t byte_s;     // accepted beats
	block_done_t block_s;   // finished blocks
	result_t crc_res;
	result_t ext_res;
	fn_sel_e fn_cur;
	logic stall;

	block_collector i_collector (
		.clk       (clk),
		.rst       (rst),
		.in_en     (in_en),
		.iot_in    (iot_in),
		.busy      (busy),
		.byte_out  (byte_s),
		.block_out (block_s)
	);

	crc3_engine i_crc (
		.clk      (clk),
		.rst      (rst),
		.fn_sel   (fn_cur),
		.block_in (block_s),
		.crc_res  (crc_res)
	);

	extreme_tracker i_ext (
		.clk      (clk),
		.rst      (rst),
		.fn_sel   (fn_cur),
		.byte_in  (byte_s),
		.block_in (block_s),
		.ext_res  (ext_res),
		.stall    (stall)
	);

	iotdf_ctrl i_ctrl (
		.clk     (clk),
		.rst     (rst),
		.fn_sel  (fn_sel),
		.stall   (stall),
		.crc_res (crc_res),
		.ext_res (ext_res),
		.fn_cur  (fn_cur),
		.busy    (busy),
		.valid   (valid),
		.iot_out (iot_out)
	);

endmodule

`default_nettype wire

/* src/iotdf_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module iotdf_ctrl
	import iotdf_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic [2:0] fn_sel,
	input  logic stall,
	input  result_t crc_res,
	input  result_t ext_res,
	output fn_sel_e fn_cur,
	output logic busy,
	output logic valid,
	output block_t iot_out
);

	logic [2:0] fn_q;
	logic busy_q;
	logic crc_act;
	logic ext_act;
	result_t sel_res;

	// ----------------------------------------
	// function register
	// ----------------------------------------
	// follows fn_sel on every edge, settled once rst drops
	always_ff @(posedge clk) begin
		fn_q <= fn_sel;
	end

	assign fn_cur = fn_sel_e'(fn_q);
	assign crc_act = fn_cur == fn_crc_gen;
	assign ext_act = (fn_cur == fn_top2max) || (fn_cur == fn_last2min);

	// busy high through reset, then one cycle behind stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			busy_q <= 1'b1;
		else
			busy_q <= stall;
	end

	// result select
	always_comb begin
		sel_res = '0;               // unused codes give nothing
		if (crc_act)
			sel_res = crc_res;
		else if (ext_act)
			sel_res = ext_res;
	end

	assign busy = busy_q;
	assign valid = sel_res.valid;
	assign iot_out = sel_res.data;

	// engines decode fn_cur on their own
	a_crc_sel: assert property (@(posedge clk) disable iff (rst)
		crc_res.valid |-> crc_act);
	a_ext_sel: assert property (@(posedge clk) disable iff (rst)
		ext_res.valid |-> ext_act);

endmodule

`default_nettype wire

/* src/extreme_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iotdf_defs.svh"

module extreme_tracker
	import iotdf_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  fn_sel_e fn_sel,
	input  byte_strb_t byte_in,
	input  block_done_t block_in,
	output result_t ext_res,
	output logic stall
);

	localparam logic [1:0] PH_IDLE   = 2'd0;
	localparam logic [1:0] PH_FIRST  = 2'd1;  // showing first entry
	localparam logic [1:0] PH_SECOND = 2'd2;  // showing second entry
	localparam logic [1:0] PH_INIT   = 2'd3;  // entries not yet set after reset

	logic own;                 // top2max or last2min active
	logic is_min;
	logic round_end;           // eighth block completes this cycle
	logic reinit;
	logic [1:0] phase;
	block_t init_val;
	block_t e0;                // largest / smallest
	block_t e1;                // runner up
	block_t e0_nxt;
	block_t e1_nxt;
	block_t r0;                // compare references
	block_t r1;
	logic [`IOT_BYTE_W-1:0] lane0;
	logic [`IOT_BYTE_W-1:0] lane1;
	logic gt0;                 // block above e0 so far
	logic gt1;                 // block above e1 so far
	logic gt0_nxt;
	logic gt1_nxt;
	logic beats0;              // block displaces e0
	logic ins;                 // block enters the pair

	assign own = (fn_sel == fn_top2max) || (fn_sel == fn_last2min);
	assign is_min = fn_sel == fn_last2min;
	assign init_val = is_min ? '1 : '0;
	assign round_end = block_in.strb && block_in.last && own;
	assign reinit = (phase == PH_SECOND) || (phase == PH_INIT);

	// max keeps strictly greater, min keeps less or equal
	assign beats0 = is_min ? !gt0 : gt0;
	assign ins = is_min ? !gt1 : gt1;

	// ----------------------------------------
	// sorted entry pair
	// ----------------------------------------
	always_comb begin
		e0_nxt = e0;
		e1_nxt = e1;
		if (reinit) begin
			e0_nxt = init_val;
			e1_nxt = init_val;
		end else if (block_in.strb && own && ins) begin
			if (beats0) begin
				e0_nxt = block_in.data;
				e1_nxt = e0;        // old leader moves down
			end else begin
				e1_nxt = block_in.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		e0 <= e0_nxt;
		e1 <= e1_nxt;
	end

	// ----------------------------------------
	// byte serial compare
	// ----------------------------------------
	// beat after a round end belongs to the fresh round
	assign r0 = round_end ? init_val : e0_nxt;
	assign r1 = round_end ? init_val : e1_nxt;
	assign lane0 = r0[{byte_in.idx, 3'b000} +: `IOT_BYTE_W];
	assign lane1 = r1[{byte_in.idx, 3'b000} +: `IOT_BYTE_W];

	always_comb begin
		gt0_nxt = byte_in.data > lane0;
		gt1_nxt = byte_in.data > lane1;
		if (byte_in.idx != '0) begin  // lane 0 starts clean
			if (byte_in.data == lane0)
				gt0_nxt = gt0;          // tie keeps lower lanes' verdict
			if (byte_in.data == lane1)
				gt1_nxt = gt1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			gt0 <= 1'b0;
			gt1 <= 1'b0;
		end else if (byte_in.strb) begin
			gt0 <= gt0_nxt;
			gt1 <= gt1_nxt;
		end
	end

	// two output cycles then reinit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_INIT;
		end else begin
			case (phase)
				PH_IDLE:
					if (round_end)
						phase <= PH_FIRST;
				PH_FIRST:
					phase <= PH_SECOND;
				default:
					phase <= PH_IDLE;  // second or init
			endcase
		end
	end

	assign stall = round_end || (phase == PH_FIRST);
	assign ext_res.valid = (phase == PH_FIRST) || (phase == PH_SECOND);
	assign ext_res.data = (phase == PH_FIRST) ? e0 : e1;

	// pair stays sorted in the active direction
	a_order: assert property (@(posedge clk) disable iff (rst)
		(own && phase != PH_INIT) |-> (is_min ? (e0 <= e1) : (e0 >= e1)));

endmodule

`default_nettype wire

/* src/crc3_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iotdf_defs.svh"

module crc3_engine
	import iotdf_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  fn_sel_e fn_sel,
	input  block_done_t block_in,
	output result_t crc_res
);

	localparam int DVD_W = `IOT_BLOCK_W + `IOT_CRC_W;  // block times x^3
	localparam int WIN_W = `IOT_BYTE_W + `IOT_CRC_W;   // 11 bit window
	localparam int STEPS = `IOT_BLOCK_BYTES;           // 11 + 15 x 8 = 131
	localparam int CNT_W = $clog2(STEPS);

	logic cap;                  // block taken into the wait slot
	logic load;                 // wait slot into the divider
	logic pend_full;
	block_t pend;
	logic [DVD_W-1:0] dvd;      // working dividend
	logic run;
	logic [CNT_W-1:0] step_cnt;
	logic fin;                  // remainder sits in dvd top bits
	logic res_vld;
	logic [`IOT_CRC_W-1:0] rem_q;

	// remainder of one window, msb first
	function automatic logic [`IOT_CRC_W-1:0] win_rem(input logic [WIN_W-1:0] win);
		logic [WIN_W-1:0] v;
		v = win;
		for (int i = WIN_W - 1; i >= `IOT_CRC_W; i--) begin
			if (v[i])
				v[i -: (`IOT_CRC_W + 1)] = v[i -: (`IOT_CRC_W + 1)] ^ `IOT_CRC_POLY;
		end
		return v[`IOT_CRC_W-1:0];
	endfunction

	// reduce top window and move 8 fresh bits up
	function automatic logic [DVD_W-1:0] div_step(input logic [DVD_W-1:0] d);
		return {win_rem(d[DVD_W-1 -: WIN_W]), d[DVD_W-WIN_W-1:0], {`IOT_BYTE_W{1'b0}}};
	endfunction

	assign cap = block_in.strb && (fn_sel == fn_crc_gen);
	assign load = pend_full && !run;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend_full <= 1'b0;
			run <= 1'b0;
			step_cnt <= '0;
			fin <= 1'b0;
			res_vld <= 1'b0;
		end else begin
			pend_full <= cap || (pend_full && run);  // waits while dividing
			fin <= 1'b0;
			res_vld <= fin;                           // single valid cycle
			if (load) begin
				run <= 1'b1;
				step_cnt <= '0;
			end else if (run) begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == CNT_W'(STEPS - 2)) begin  // first step done on load
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	// ----------------------------------------
	// divider data path
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cap)
			pend <= block_in.data;
		if (load)
			dvd <= div_step({pend, {`IOT_CRC_W{1'b0}}});
		else if (run)
			dvd <= div_step(dvd);
		if (fin)
			rem_q <= dvd[DVD_W-1 -: `IOT_CRC_W];
	end

	assign crc_res.valid = res_vld;
	assign crc_res.data = block_t'(rem_q);  // zero extended

	// blocks sixteen beats apart never find the slot occupied
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		cap |-> !pend_full);

endmodule

`default_nettype wire

/* src/block_collector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iotdf_defs.svh"

module block_collector
	import iotdf_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic in_en,
	input  logic [`IOT_BYTE_W-1:0] iot_in,
	input  logic busy,
	output byte_strb_t byte_out,
	output block_done_t block_out
);

	localparam int IDX_W = $clog2(`IOT_BLOCK_BYTES);
	localparam int BLK_W = $clog2(`IOT_ROUND_BLOCKS);

	logic accept;             // beat taken this edge
	logic blk_end;            // sixteenth beat this edge
	logic round_last;         // current block closes the round
	logic [IDX_W-1:0] byte_cnt;
	logic [BLK_W-1:0] blk_cnt;
	block_t asm_q;            // assembly register
	logic done_q;
	logic last_q;

	assign accept = in_en && !busy;
	assign blk_end = accept && (byte_cnt == IDX_W'(`IOT_BLOCK_BYTES - 1));
	assign round_last = blk_cnt == BLK_W'(`IOT_ROUND_BLOCKS - 1);

	// ----------------------------------------
	// beat stream to the comparators
	// ----------------------------------------
	assign byte_out.data = iot_in;
	assign byte_out.idx = byte_cnt;
	assign byte_out.strb = accept;

	// byte and block-in-round counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt <= '0;
			blk_cnt <= '0;
		end else if (accept) begin
			byte_cnt <= blk_end ? '0 : byte_cnt + 1'b1;
			if (blk_end)
				blk_cnt <= round_last ? '0 : blk_cnt + 1'b1;  // new round
		end
	end

	// completion pulse one cycle after the last beat
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			done_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			done_q <= blk_end;
			last_q <= blk_end && round_last;
		end
	end

	// first beat lands in bits 7..0
	always_ff @(posedge clk) begin
		if (accept)
			asm_q[{byte_cnt, 3'b000} +: `IOT_BYTE_W] <= iot_in;
	end

	assign block_out.data = asm_q;  // complete while done_q is high
	assign block_out.last = last_q;
	assign block_out.strb = done_q;

	// stall only arrives while a round is starting
	a_cnt_hold: assert property (@(posedge clk) disable iff (rst)
		busy |-> (blk_cnt == '0) && (byte_cnt <= IDX_W'(1)));

endmodule

`default_nettype wire

/* src/iotdf_pkg.sv */
`default_nettype none

`include "iotdf_defs.svh"

package iotdf_pkg;

	// function code on fn_sel
	typedef enum logic [2:0] {
		fn_crc_gen  = 3'd3,
		fn_top2max  = 3'd4,
		fn_last2min = 3'd5
	} fn_sel_e;

	typedef logic [`IOT_BLOCK_W-1:0] block_t;

	// one accepted input beat
	typedef struct packed {
		logic [`IOT_BYTE_W-1:0] data;
		logic [$clog2(`IOT_BLOCK_BYTES)-1:0] idx;  // lane in the block
		logic strb;                                // in_en and not busy
	} byte_strb_t;

	// one finished block
	typedef struct packed {
		block_t data;
		logic last;  // eighth block of a round
		logic strb;  // single cycle
	} block_done_t;

	typedef struct packed {
		logic valid;
		block_t data;
	} result_t;

endpackage

`default_nettype wire

/* src/iotdf_defs.svh */
`ifndef IOTDF_DEFS_SVH
`define IOTDF_DEFS_SVH

// ----------------------------------------
// stream and block geometry
// ----------------------------------------
`define IOT_BYTE_W       8    // one input beat
`define IOT_BLOCK_BYTES  16   // beats per block
`define IOT_BLOCK_W      128  // beats x byte width

// blocks per round for top2max / last2min
`define IOT_ROUND_BLOCKS 8

// ----------------------------------------
// crc
// ----------------------------------------
`define IOT_CRC_W        3
`define IOT_CRC_POLY     4'b1101  // x^3 + x^2 + 1

`endif
